// ==== design/key_extract_pkg.sv ====
package key_extract_pkg;

    // container geometry
    localparam int width_2b = 16;
    localparam int width_4b = 32;
    localparam int width_6b = 48;
    localparam int num_conts = 8;
    localparam int num_ops = 5;
    localparam int meta_len = 256;
    localparam int phv_len = num_conts * (width_6b + width_4b + width_2b) + num_ops * 20
                             + meta_len;

    // key is two fields of each size plus one compare bit per stage
    localparam int key_len = 2 * width_6b + 2 * width_4b + 2 * width_2b + num_ops;
    localparam int key_off_len = 18;

    localparam int table_depth = 16;
    localparam int table_addr_w = 4;

    localparam int ctrl_data_w = 512;

    // control header field positions
    localparam int mod_id_lsb = 368;
    localparam int sub_type_lsb = 380;
    localparam int index_lsb = 384;
    // tenant index inside the metadata, low end of the phv
    localparam int vlan_idx_lsb = 133;

    typedef enum logic [1:0] {
        cmp_gt   = 2'd0,
        cmp_ge   = 2'd1,
        cmp_eq   = 2'd2,
        cmp_true = 2'd3
    } cmp_op_e;

    // container reference: type 2 = 6b, 1 = 4b, 0 = 2b
    typedef struct packed {
        logic [2:0] pad;
        logic [1:0] ctype;
        logic [2:0] idx;
    } opnd_sel_t;

    // operand field is an immediate or a container reference
    typedef union packed {
        logic [7:0] imm_val;
        opnd_sel_t  sel;
    } opnd_t;

    typedef struct packed {
        cmp_op_e op;
        logic    imm_a;
        opnd_t   opnd_a;
        logic    imm_b;
        opnd_t   opnd_b;
    } com_op_t;

    typedef struct packed {
        logic [num_conts-1:0][width_6b-1:0] cont_6b;
        logic [num_conts-1:0][width_4b-1:0] cont_4b;
        logic [num_conts-1:0][width_2b-1:0] cont_2b;
        com_op_t [0:num_ops-1]              com_op;
        logic [meta_len-1:0]                meta;
    } phv_t;

    typedef struct packed {
        logic [2:0] off_6b_0;
        logic [2:0] off_6b_1;
        logic [2:0] off_4b_0;
        logic [2:0] off_4b_1;
        logic [2:0] off_2b_0;
        logic [2:0] off_2b_1;
    } key_off_t;

    typedef struct packed {
        logic [width_6b-1:0] f6_0;
        logic [width_6b-1:0] f6_1;
        logic [width_4b-1:0] f4_0;
        logic [width_4b-1:0] f4_1;
        logic [width_2b-1:0] f2_0;
        logic [width_2b-1:0] f2_1;
    } key_fields_t;

    typedef struct packed {
        key_fields_t        fields;
        logic [num_ops-1:0] cmp;
    } key_t;

    typedef struct packed {
        logic [ctrl_data_w-1:0] data;
        logic                   valid;
        logic                   last;
    } ctrl_beat_t;

endpackage

// ==== design/key_config_table.sv ====
`timescale 1ns/100ps

module key_config_table #(
    parameter type payload_t = logic
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wr_en,
    input  logic [key_extract_pkg::table_addr_w-1:0] wr_addr,
    input  payload_t                                wr_data,
    input  logic [key_extract_pkg::table_addr_w-1:0] rd_addr,
    output payload_t                                rd_data
);

    payload_t mem [key_extract_pkg::table_depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read, a write is seen by the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== design/key_table_writer.sv ====
`timescale 1ns/100ps

module key_table_writer #(
    parameter int unsigned stage_id = 0,
    parameter int unsigned key_ex_id = 0
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  key_extract_pkg::ctrl_beat_t             ctrl_in,
    output key_extract_pkg::ctrl_beat_t             ctrl_out,
    output logic                                    wr_en_off,
    output logic                                    wr_en_mask,
    output logic [key_extract_pkg::table_addr_w-1:0] wr_addr,
    output key_extract_pkg::key_off_t               wr_data_off,
    output logic [key_extract_pkg::key_len-1:0]     wr_data_mask
);

    // upper five bits select the stage, lower three the module
    localparam logic [7:0] own_mod_id = {5'(stage_id), 3'(key_ex_id)};

    typedef enum logic [1:0] {
        st_idle,
        st_wr_off,
        st_wr_mask
    } state_t;

    state_t     state;
    logic       first_beat;
    logic       hdr_match;
    logic [7:0] beat_mod_id;
    logic [3:0] beat_sub_type;

    assign beat_mod_id = ctrl_in.data[key_extract_pkg::mod_id_lsb +: 8];
    assign beat_sub_type = ctrl_in.data[key_extract_pkg::sub_type_lsb +: 4];

    // only a packet's first beat carries a header worth matching
    assign hdr_match = ctrl_in.valid && first_beat && (beat_mod_id == own_mod_id);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_beat <= 1'b1;
        end else if (ctrl_in.valid) begin
            first_beat <= ctrl_in.last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            wr_addr <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (hdr_match) begin
                        wr_addr <= ctrl_in.data[key_extract_pkg::index_lsb +:
                                                key_extract_pkg::table_addr_w];
                        // a header-only packet has nothing to load
                        if (!ctrl_in.last) begin
                            state <= (beat_sub_type == 4'd0) ? st_wr_off : st_wr_mask;
                        end
                    end
                end
                st_wr_off, st_wr_mask: begin
                    if (ctrl_in.valid) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (ctrl_in.last) begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // entry is written on the edge that takes the beat
    assign wr_en_off = (state == st_wr_off) && ctrl_in.valid;
    assign wr_en_mask = (state == st_wr_mask) && ctrl_in.valid;
    assign wr_data_off = ctrl_in.data[key_extract_pkg::key_off_len-1:0];
    assign wr_data_mask = ctrl_in.data[key_extract_pkg::key_len-1:0];

    // foreign traffic goes out one cycle later, own packets are swallowed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_out <= '0;
        end else if (state == st_idle && !hdr_match) begin
            ctrl_out <= ctrl_in;
        end else begin
            ctrl_out.valid <= 1'b0;
            ctrl_out.last <= 1'b0;
        end
    end

endmodule

// ==== design/key_field_selector.sv ====
`timescale 1ns/100ps

module key_field_selector (
    input  logic                         clk,
    input  logic                         rst_n,
    input  key_extract_pkg::phv_t        phv_s1,
    input  key_extract_pkg::key_off_t    key_offset,
    output key_extract_pkg::key_fields_t fields_s2
);

    key_extract_pkg::key_fields_t fields_next;

    // offset entry arrives with the phv it was looked up for
    always_comb begin
        fields_next.f6_0 = phv_s1.cont_6b[key_offset.off_6b_0];
        fields_next.f6_1 = phv_s1.cont_6b[key_offset.off_6b_1];
        fields_next.f4_0 = phv_s1.cont_4b[key_offset.off_4b_0];
        fields_next.f4_1 = phv_s1.cont_4b[key_offset.off_4b_1];
        fields_next.f2_0 = phv_s1.cont_2b[key_offset.off_2b_0];
        fields_next.f2_1 = phv_s1.cont_2b[key_offset.off_2b_1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fields_s2 <= '0;
        end else begin
            fields_s2 <= fields_next;
        end
    end

endmodule

// ==== design/key_comparator.sv ====
`timescale 1ns/100ps

module key_comparator #(
    parameter int unsigned stage_id = 0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  key_extract_pkg::phv_t               phv_s1,
    output logic [key_extract_pkg::num_ops-1:0] cmp_s2
);

    key_extract_pkg::com_op_t            op_sel;
    logic [7:0]                          opnd_a;
    logic [7:0]                          opnd_b;
    logic                                result;
    logic [key_extract_pkg::num_ops-1:0] cmp_next;

    // low byte of the referenced container, or the immediate
    function automatic logic [7:0] fetch_opnd(input logic imm,
                                              input key_extract_pkg::opnd_t opnd,
                                              input key_extract_pkg::phv_t phv);
        logic [7:0] val;
        val = 8'd0;
        if (imm) begin
            val = opnd.imm_val;
        end else begin
            case (opnd.sel.ctype)
                2'd2: val = phv.cont_6b[opnd.sel.idx][7:0];
                2'd1: val = phv.cont_4b[opnd.sel.idx][7:0];
                2'd0: val = phv.cont_2b[opnd.sel.idx][7:0];
                default: val = 8'd0;
            endcase
        end
        return val;
    endfunction

    assign op_sel = phv_s1.com_op[stage_id];
    assign opnd_a = fetch_opnd(op_sel.imm_a, op_sel.opnd_a, phv_s1);
    assign opnd_b = fetch_opnd(op_sel.imm_b, op_sel.opnd_b, phv_s1);

    always_comb begin
        case (op_sel.op)
            key_extract_pkg::cmp_gt: result = (opnd_a > opnd_b);
            key_extract_pkg::cmp_ge: result = (opnd_a >= opnd_b);
            key_extract_pkg::cmp_eq: result = (opnd_a == opnd_b);
            default: result = 1'b1;
        endcase
        // stage 0 owns the top bit of the compare vector
        cmp_next = '0;
        cmp_next[key_extract_pkg::num_ops-1-stage_id] = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_s2 <= '0;
        end else begin
            cmp_s2 <= cmp_next;
        end
    end

endmodule

// ==== design/key_assembler.sv ====
`timescale 1ns/100ps

module key_assembler (
    input  logic                                clk,
    input  logic                                rst_n,
    input  key_extract_pkg::phv_t               phv_in,
    input  logic                                phv_valid_in,
    input  logic [key_extract_pkg::key_len-1:0] mask_rd,
    input  key_extract_pkg::key_fields_t        fields_s2,
    input  logic [key_extract_pkg::num_ops-1:0] cmp_s2,
    output key_extract_pkg::phv_t               phv_s1,
    output key_extract_pkg::phv_t               phv_out,
    output logic                                phv_valid_out,
    output key_extract_pkg::key_t               key_out,
    output logic                                key_valid_out,
    output logic [key_extract_pkg::key_len-1:0] key_mask_out
);

    logic                                valid_s1;
    logic                                valid_s2;
    key_extract_pkg::phv_t               phv_s2;
    logic [key_extract_pkg::key_len-1:0] mask_s2;

    // stage 1 lines up with the table reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_s1 <= '0;
            valid_s1 <= 1'b0;
            phv_s2 <= '0;
            valid_s2 <= 1'b0;
            mask_s2 <= '0;
        end else begin
            phv_s1 <= phv_in;
            valid_s1 <= phv_valid_in;
            phv_s2 <= phv_s1;
            valid_s2 <= valid_s1;
            // mask needs one more cycle to meet the selected fields
            mask_s2 <= mask_rd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out <= '0;
            phv_valid_out <= 1'b0;
            key_out <= '0;
            key_valid_out <= 1'b0;
            key_mask_out <= '0;
        end else begin
            phv_out <= phv_s2;
            phv_valid_out <= valid_s2;
            key_valid_out <= valid_s2;
            // key and mask hold between items
            if (valid_s2) begin
                key_out.fields <= fields_s2;
                key_out.cmp <= cmp_s2;
                key_mask_out <= mask_s2;
            end
        end
    end

endmodule

// ==== design/key_extract.sv ====
`timescale 1ns/100ps

module key_extract #(
    parameter int unsigned stage_id = 0,
    parameter int unsigned key_ex_id = 0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  key_extract_pkg::phv_t               phv_in,
    input  logic                                phv_valid_in,
    output key_extract_pkg::phv_t               phv_out,
    output logic                                phv_valid_out,
    output key_extract_pkg::key_t               key_out,
    output logic                                key_valid_out,
    output logic [key_extract_pkg::key_len-1:0] key_mask_out,
    input  key_extract_pkg::ctrl_beat_t         ctrl_in,
    output key_extract_pkg::ctrl_beat_t         ctrl_out
);

    logic [key_extract_pkg::phv_len-1:0]      phv_flat;
    logic [key_extract_pkg::table_addr_w-1:0] rd_addr;
    logic                                     wr_en_off;
    logic                                     wr_en_mask;
    logic [key_extract_pkg::table_addr_w-1:0] wr_addr;
    key_extract_pkg::key_off_t                wr_data_off;
    logic [key_extract_pkg::key_len-1:0]      wr_data_mask;
    key_extract_pkg::key_off_t                key_offset;
    logic [key_extract_pkg::key_len-1:0]      mask_rd;
    key_extract_pkg::phv_t                    phv_s1;
    key_extract_pkg::key_fields_t             fields_s2;
    logic [key_extract_pkg::num_ops-1:0]      cmp_s2;

    // tenant index taken from the vlan id in the metadata
    assign phv_flat = phv_in;
    assign rd_addr = phv_flat[key_extract_pkg::vlan_idx_lsb +: key_extract_pkg::table_addr_w];

    key_table_writer #(
        .stage_id  (stage_id),
        .key_ex_id (key_ex_id)
    ) key_table_writer_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl_in      (ctrl_in),
        .ctrl_out     (ctrl_out),
        .wr_en_off    (wr_en_off),
        .wr_en_mask   (wr_en_mask),
        .wr_addr      (wr_addr),
        .wr_data_off  (wr_data_off),
        .wr_data_mask (wr_data_mask)
    );

    key_config_table #(
        .payload_t (key_extract_pkg::key_off_t)
    ) offset_table_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en_off),
        .wr_addr (wr_addr),
        .wr_data (wr_data_off),
        .rd_addr (rd_addr),
        .rd_data (key_offset)
    );

    key_config_table #(
        .payload_t (logic [key_extract_pkg::key_len-1:0])
    ) mask_table_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en_mask),
        .wr_addr (wr_addr),
        .wr_data (wr_data_mask),
        .rd_addr (rd_addr),
        .rd_data (mask_rd)
    );

    key_field_selector key_field_selector_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .phv_s1     (phv_s1),
        .key_offset (key_offset),
        .fields_s2  (fields_s2)
    );

    key_comparator #(
        .stage_id (stage_id)
    ) key_comparator_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .phv_s1 (phv_s1),
        .cmp_s2 (cmp_s2)
    );

    key_assembler key_assembler_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .mask_rd       (mask_rd),
        .fields_s2     (fields_s2),
        .cmp_s2        (cmp_s2),
        .phv_s1        (phv_s1),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

// ==== sim/key_extract_checker.sv ====
`timescale 1ns/100ps

module key_extract_checker #(
    parameter int unsigned stage_id = 0,
    parameter int unsigned key_ex_id = 0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  key_extract_pkg::phv_t               phv_in,
    input  logic                                phv_valid_in,
    input  key_extract_pkg::ctrl_beat_t         ctrl_in,
    input  key_extract_pkg::phv_t               phv_out,
    input  logic                                phv_valid_out,
    input  key_extract_pkg::key_t               key_out,
    input  logic                                key_valid_out,
    input  logic [key_extract_pkg::key_len-1:0] key_mask_out,
    input  key_extract_pkg::ctrl_beat_t         ctrl_out,
    output int                                  mismatch_count,
    output int                                  pending
);

    typedef struct packed {
        key_extract_pkg::phv_t               phv;
        key_extract_pkg::key_t               key;
        logic [key_extract_pkg::key_len-1:0] mask;
        int                                  due;
    } expect_t;

    expect_t                             exp_q[$];
    expect_t                             head;
    key_extract_pkg::key_off_t           shadow_off [key_extract_pkg::table_depth];
    logic [key_extract_pkg::key_len-1:0] shadow_mask [key_extract_pkg::table_depth];
    key_extract_pkg::ctrl_beat_t         exp_ctrl;
    logic                                first_beat;
    logic                                own_pkt;
    logic                                to_mask;
    logic [3:0]                          wr_idx;
    int                                  cycle;
    bit                                  due_now;

    task automatic report_value(input string name,
                                input logic [key_extract_pkg::phv_len-1:0] exp_val,
                                input logic [key_extract_pkg::phv_len-1:0] act_val);
        $display("** Error at %0d ns: %s expected %0h, actual %0h",
                 $time, name, exp_val, act_val);
        mismatch_count++;
    endtask

    // immediate, or low byte of container val[2:0] of type val[4:3]
    function automatic logic [7:0] operand(input logic imm, input logic [7:0] val,
                                           input key_extract_pkg::phv_t p);
        if (imm) begin
            return val;
        end
        case (val[4:3])
            2'd2: return p.cont_6b[val[2:0]][7:0];
            2'd1: return p.cont_4b[val[2:0]][7:0];
            2'd0: return p.cont_2b[val[2:0]][7:0];
            default: return 8'd0;
        endcase
    endfunction

    function automatic expect_t predict(input key_extract_pkg::phv_t p, input int due);
        expect_t                   e;
        key_extract_pkg::key_off_t o;
        key_extract_pkg::com_op_t  op;
        logic [3:0]                idx;
        logic [7:0]                a;
        logic [7:0]                b;
        logic                      hit;
        idx = p.meta[key_extract_pkg::vlan_idx_lsb +: 4];
        o = shadow_off[idx];
        e.phv = p;
        e.mask = shadow_mask[idx];
        e.due = due;
        e.key.fields.f6_0 = p.cont_6b[o.off_6b_0];
        e.key.fields.f6_1 = p.cont_6b[o.off_6b_1];
        e.key.fields.f4_0 = p.cont_4b[o.off_4b_0];
        e.key.fields.f4_1 = p.cont_4b[o.off_4b_1];
        e.key.fields.f2_0 = p.cont_2b[o.off_2b_0];
        e.key.fields.f2_1 = p.cont_2b[o.off_2b_1];
        op = p.com_op[stage_id];
        a = operand(op.imm_a, op.opnd_a, p);
        b = operand(op.imm_b, op.opnd_b, p);
        case (op.op)
            key_extract_pkg::cmp_gt: hit = (a > b);
            key_extract_pkg::cmp_ge: hit = (a >= b);
            key_extract_pkg::cmp_eq: hit = (a == b);
            default: hit = 1'b1;
        endcase
        e.key.cmp = '0;
        e.key.cmp[key_extract_pkg::num_ops - 1 - stage_id] = hit;
        return e;
    endfunction

    // shadows the table writer and expects foreign beats one cycle later
    task automatic track_ctrl(input key_extract_pkg::ctrl_beat_t beat);
        logic [7:0] mod_id;
        mod_id = beat.data[key_extract_pkg::mod_id_lsb +: 8];
        exp_ctrl = '0;
        if (beat.valid) begin
            if (first_beat) begin
                own_pkt = (mod_id == 8'(stage_id * 8 + key_ex_id));
                if (own_pkt) begin
                    wr_idx = beat.data[key_extract_pkg::index_lsb +: 4];
                    to_mask = (beat.data[key_extract_pkg::sub_type_lsb +: 4] != 4'd0);
                end else begin
                    exp_ctrl = beat;
                end
            end else if (own_pkt) begin
                if (to_mask) begin
                    shadow_mask[wr_idx] = beat.data[key_extract_pkg::key_len-1:0];
                end else begin
                    shadow_off[wr_idx] = beat.data[key_extract_pkg::key_off_len-1:0];
                end
                wr_idx = wr_idx + 4'd1;
            end else begin
                exp_ctrl = beat;
            end
            first_beat = beat.last;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            exp_ctrl = '0;
            first_beat = 1'b1;
            own_pkt = 1'b0;
            to_mask = 1'b0;
            wr_idx = '0;
            cycle = 0;
            mismatch_count = 0;
            pending = 0;
        end else begin
            cycle++;
            due_now = (exp_q.size() > 0) && (exp_q[0].due == cycle);
            if (phv_valid_out !== due_now) begin
                report_value("phv_valid_out", due_now, phv_valid_out);
            end
            if (key_valid_out !== due_now) begin
                report_value("key_valid_out", due_now, key_valid_out);
            end
            if (due_now) begin
                head = exp_q.pop_front();
                if (phv_valid_out) begin
                    if (phv_out !== head.phv) begin
                        report_value("phv_out", head.phv, phv_out);
                    end
                    if (key_out !== head.key) begin
                        report_value("key_out", head.key, key_out);
                    end
                    if (key_mask_out !== head.mask) begin
                        report_value("key_mask_out", head.mask, key_mask_out);
                    end
                end
            end
            if (ctrl_out.valid !== exp_ctrl.valid) begin
                report_value("ctrl_out.valid", exp_ctrl.valid, ctrl_out.valid);
            end else if (exp_ctrl.valid && ctrl_out !== exp_ctrl) begin
                report_value("ctrl_out", exp_ctrl, ctrl_out);
            end
            // prediction uses the tables as they were before this edge's write
            if (phv_valid_in) begin
                exp_q.push_back(predict(phv_in, cycle + 3));
            end
            track_ctrl(ctrl_in);
            pending = exp_q.size() + (exp_ctrl.valid ? 1 : 0);
        end
    end

endmodule

// ==== sim/tb_key_extract.sv ====
`timescale 1ns/100ps

module tb_key_extract;

    localparam int unsigned stage_id = 2;
    localparam int unsigned key_ex_id = 5;
    localparam logic [7:0] own_mod_id = 8'(stage_id * 8 + key_ex_id);

    localparam int num_items = 400;
    localparam int num_cfg_pkts = 4;
    localparam int cfg_body_beats = 16;
    localparam int num_foreign_pkts = 12;
    localparam int max_foreign_beats = 4;
    localparam int total_beats = num_cfg_pkts * (cfg_body_beats + 1)
                                 + num_foreign_pkts * max_foreign_beats + num_items;
    // every beat may be followed by one idle cycle
    localparam int watchdog_ns = total_beats * 100 * 2 + 5000;

    logic                                clk;
    logic                                rst_n;
    key_extract_pkg::phv_t               phv_in;
    logic                                phv_valid_in;
    key_extract_pkg::phv_t               phv_out;
    logic                                phv_valid_out;
    key_extract_pkg::key_t               key_out;
    logic                                key_valid_out;
    logic [key_extract_pkg::key_len-1:0] key_mask_out;
    key_extract_pkg::ctrl_beat_t         ctrl_in;
    key_extract_pkg::ctrl_beat_t         ctrl_out;
    int                                  mismatch_count;
    int                                  pending;

    always #50 clk = ~clk;

    key_extract #(
        .stage_id  (stage_id),
        .key_ex_id (key_ex_id)
    ) key_extract_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out),
        .ctrl_in       (ctrl_in),
        .ctrl_out      (ctrl_out)
    );

    key_extract_checker #(
        .stage_id  (stage_id),
        .key_ex_id (key_ex_id)
    ) key_extract_checker_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ctrl_in        (ctrl_in),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out        (key_out),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out),
        .ctrl_out       (ctrl_out),
        .mismatch_count (mismatch_count),
        .pending        (pending)
    );

    function automatic logic [1151:0] random_bits();
        logic [1151:0] bits;
        for (int i = 0; i < 36; i++) begin
            bits[i*32 +: 32] = $urandom();
        end
        return bits;
    endfunction

    // inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic send_beat(input logic [key_extract_pkg::ctrl_data_w-1:0] data,
                             input logic last);
        ctrl_in.data = data;
        ctrl_in.valid = 1'b1;
        ctrl_in.last = last;
        next_cycle();
        ctrl_in.valid = 1'b0;
        ctrl_in.last = 1'b0;
        if ($urandom_range(3) == 0) begin
            next_cycle();
        end
    endtask

    task automatic send_packet(input logic [7:0] mod_id, input logic [3:0] sub_type,
                               input logic [3:0] index, input int body_beats);
        logic [1151:0]                          bits;
        logic [key_extract_pkg::ctrl_data_w-1:0] data;
        bits = random_bits();
        data = bits[key_extract_pkg::ctrl_data_w-1:0];
        data[key_extract_pkg::mod_id_lsb +: 8] = mod_id;
        data[key_extract_pkg::sub_type_lsb +: 4] = sub_type;
        // upper index bits are ignored by the table
        data[key_extract_pkg::index_lsb +: 8] = {4'($urandom_range(15)), index};
        send_beat(data, body_beats == 0);
        for (int i = 1; i <= body_beats; i++) begin
            bits = random_bits();
            data = bits[key_extract_pkg::ctrl_data_w-1:0];
            // body beat that looks like an own header
            data[key_extract_pkg::mod_id_lsb +: 8] = own_mod_id;
            send_beat(data, i == body_beats);
        end
    endtask

    task automatic drive_phv();
        logic [1151:0]         bits;
        key_extract_pkg::phv_t p;
        bits = random_bits();
        p = bits[key_extract_pkg::phv_len-1:0];
        // equal immediates now and then so the equal compare can hit
        if ($urandom_range(3) == 0) begin
            p.com_op[stage_id].imm_a = 1'b1;
            p.com_op[stage_id].imm_b = 1'b1;
            p.com_op[stage_id].opnd_b = p.com_op[stage_id].opnd_a;
        end
        phv_in = p;
        phv_valid_in = 1'b1;
        next_cycle();
        phv_valid_in = 1'b0;
        if ($urandom_range(3) == 0) begin
            next_cycle();
        end
    endtask

    initial begin
        logic [7:0] mod_id;
        clk = 1'b0;
        rst_n = 1'b0;
        phv_in = '0;
        phv_valid_in = 1'b0;
        ctrl_in = '0;
        void'($urandom(16986));
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        // offset and mask packets in turn, each fills all 16 entries
        for (int p = 0; p < num_cfg_pkts; p++) begin
            send_packet(own_mod_id, (p % 2 == 0) ? 4'd0 : 4'($urandom_range(15, 1)),
                        4'($urandom_range(15)), cfg_body_beats);
        end
        for (int p = 0; p < num_foreign_pkts; p++) begin
            if (p % 2 == 0) begin
                mod_id = {5'(stage_id), 3'(key_ex_id + 1 + $urandom_range(6))};
            end else begin
                mod_id = {5'(stage_id + 1 + $urandom_range(30)), 3'(key_ex_id)};
            end
            send_packet(mod_id, 4'($urandom_range(15)), 4'($urandom_range(15)),
                        $urandom_range(max_foreign_beats - 1));
        end
        repeat (3) next_cycle();
        for (int i = 0; i < num_items; i++) begin
            drive_phv();
        end
        wait (pending == 0);
        repeat (5) @(posedge clk);
        $display("errors: %0d value mismatches, %0d expected outputs still pending",
                 mismatch_count, pending);
        if (mismatch_count == 0 && pending == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not complete within %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
design/key_extract_pkg.sv
design/key_config_table.sv
design/key_table_writer.sv
design/key_field_selector.sv
design/key_comparator.sv
design/key_assembler.sv
design/key_extract.sv
sim/key_extract_checker.sv
sim/tb_key_extract.sv

// ==== run.sh ====
#!/bin/sh
# build and run the key extract testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_key_extract \
    -f files.f -o sim_key_extract
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_key_extract)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
